/* Makefile */
SIM      = verilator
TOP      = tbVectorFunctionalUnit
FILELIST = vectorFunctionalUnit.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)

/* tbVectorFunctionalUnit.sv */
module tbVectorFunctionalUnit;
    import vfuPkg::*;

    localparam int          NumReqs = 600;
    localparam int          CyclesPerReq = 40;
    localparam int          ClkPeriod = 10;
    localparam logic [31:0] LfsrSeed = 32'd46001;
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic        CLK;
    logic        rst;
    vfuReq_t     req;
    vfuReq_t     nextReq;
    vfuResp_t    resp;
    logic        stall;
    logic [31:0] lfsr;
    int          valueErrors;
    int          otherErrors;
    int          pendingCount;
    int          issued;
    logic        held;

    vectorFunctionalUnit dut_i (
        .CLK,
        .rst,
        .req,
        .resp,
        .stall
    );

    vfuChecker checkerInst (
        .CLK,
        .rst,
        .req,
        .resp,
        .stall,
        .valueErrors,
        .otherErrors,
        .pendingCount
    );

    always #(ClkPeriod / 2) CLK = ~CLK;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic makeRequest(output vfuReq_t r);
        logic [31:0] v;
        logic [4:0]  opIdx;
        r = '0;
        takeBits(2, v);
        r.valid = (v[1:0] != 2'b00);      // 3 in 4
        takeBits(2, v);
        r.op.unit = (v[1:0] == 2'd3) ? UnitAlu : vfuUnit_e'(v[1:0]);
        takeBits(5, v);
        opIdx = 5'(v % 24);
        r.op.aluOp = aluOp_e'(opIdx);
        takeBits(2, v);
        r.op.mulOp = mulOp_e'(v[1:0]);
        takeBits(2, v);
        r.op.divOp = divOp_e'(v[1:0]);
        takeBits(1, v);
        r.op.isUnsigned = v[0];
        takeBits(1, v);
        r.maskBit = v[0];
        takeBits(2, v);
        r.sew = (v[1:0] == 2'd3) ? Sew32 : vsew_e'(v[1:0]);
        takeBits(32, v);
        r.opA = v;
        takeBits(32, v);
        r.opB = v;
        if (r.op.unit == UnitDiv) begin
            takeBits(4, v);
            if (v[3:0] == 4'd0) begin
                r.opB = '0;
            end else if (v[3:0] == 4'd1) begin
                r.opA = 32'h8000_0000;      // Signed overflow pair
                r.opB = 32'hffff_ffff;
            end
        end
    endtask

    initial begin
        CLK = 1'b0;
        rst = 1'b1;
        req = '0;
        lfsr = LfsrSeed;
        issued = 0;
        held = 1'b0;
        repeat (2) @(posedge CLK);
        #1;
        rst = 1'b0;
        while (issued < NumReqs) begin
            @(negedge CLK);
            held = req.valid && stall;
            @(posedge CLK);
            #1;
            if (!held) begin
                makeRequest(nextReq);
                req = nextReq;
                if (nextReq.valid) begin
                    issued++;
                end
            end
        end
        held = 1'b1;
        while (held) begin          // Last request still waiting on stall
            @(negedge CLK);
            held = req.valid && stall;
            @(posedge CLK);
            #1;
        end
        req.valid = 1'b0;
        for (int i = 0; (i < 2 * DivCycles) && (pendingCount != 0); i++) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
        if (pendingCount != 0) begin
            $display("%0d expected results never came back", pendingCount);
        end
        $display("Errors: %0d value mismatches, %0d other failures, %0d missing results",
                 valueErrors, otherErrors, pendingCount);
        if (valueErrors + otherErrors + pendingCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(NumReqs * CyclesPerReq * ClkPeriod);
        $display("Run timed out with %0d of %0d requests issued", issued, NumReqs);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* vectorAlu.sv */
module vectorAlu (
    input  vfuPkg::word_t  opA,
    input  vfuPkg::word_t  opB,
    input  logic           maskBit,
    input  vfuPkg::vsew_e  sew,
    input  vfuPkg::vfuOp_t op,
    output vfuPkg::word_t  result
);
    import vfuPkg::*;

    logic [$clog2(WordWidth)-1:0] shamt;
    logic                         carryIn;
    logic                         borrowIn;
    logic [WordWidth:0]           sumExt;
    logic [WordWidth:0]           diffExt;
    logic                         lessThan;
    logic                         equal;

    // Shift amount limited by element width
    always_comb begin
        case (sew)
            Sew8:    shamt = {2'b00, opB[2:0]};
            Sew16:   shamt = {1'b0, opB[3:0]};
            default: shamt = opB[4:0];
        endcase
    end

    assign carryIn = maskBit && ((op.aluOp == AluAdc) || (op.aluOp == AluMadc));
    assign borrowIn = maskBit && ((op.aluOp == AluSbc) || (op.aluOp == AluMsbc));

    // One adder and one subtractor shared by all add and subtract forms
    assign sumExt = {1'b0, opA} + {1'b0, opB} + {{WordWidth{1'b0}}, carryIn};
    assign diffExt = {1'b0, opA} - {1'b0, opB} - {{WordWidth{1'b0}}, borrowIn};

    assign equal = (opA == opB);

    always_comb begin
        if (op.isUnsigned) begin
            lessThan = (opA < opB);
        end else begin
            lessThan = ($signed(opA) < $signed(opB));
        end
    end

    always_comb begin
        result = '0;
        case (op.aluOp)
            AluAdd, AluAdc: begin
                result = sumExt[WordWidth-1:0];
            end
            AluSub, AluSbc: begin
                result = diffExt[WordWidth-1:0];
            end
            AluRsb: begin
                result = opB - opA;
            end
            AluMadc, AluMadcNoC: begin
                result = {{(WordWidth-1){1'b0}}, sumExt[WordWidth]};    // Carry out
            end
            AluMsbc, AluMsbcNoB: begin
                result = {{(WordWidth-1){1'b0}}, diffExt[WordWidth]};   // Borrow out
            end
            AluAnd: begin
                result = opA & opB;
            end
            AluOr: begin
                result = opA | opB;
            end
            AluXor: begin
                result = opA ^ opB;
            end
            AluSll: begin
                result = opA << shamt;
            end
            AluSrl: begin
                result = opA >> shamt;
            end
            AluSra: begin
                result = word_t'($signed(opA) >>> shamt);
            end
            AluSeq: begin
                result = {{(WordWidth-1){1'b0}}, equal};
            end
            AluSne: begin
                result = {{(WordWidth-1){1'b0}}, !equal};
            end
            AluSlt: begin
                result = {{(WordWidth-1){1'b0}}, lessThan};
            end
            AluSle: begin
                result = {{(WordWidth-1){1'b0}}, lessThan || equal};
            end
            AluSgt: begin
                result = {{(WordWidth-1){1'b0}}, !(lessThan || equal)};
            end
            AluMin: begin
                result = lessThan ? opA : opB;
            end
            AluMax: begin
                result = lessThan ? opB : opA;
            end
            AluMerge: begin
                result = maskBit ? opB : opA;
            end
            AluMove: begin
                result = opB;       // Also covers scalar move
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* vectorDivider.sv */
module vectorDivider (
    input  logic            CLK,
    input  logic            rst,
    input  vfuPkg::divIn_t  divIn,
    output vfuPkg::divOut_t divOut
);
    import vfuPkg::*;

    typedef enum logic [1:0] {
        DivIdle,
        DivRun,
        DivDone
    } divState_e;

    divState_e                    state;
    logic [$clog2(DivCycles)-1:0] count;
    word_t                        quo;
    word_t                        rem;
    word_t                        divisorMag;
    word_t                        dividendSave;
    logic                         negQ;
    logic                         negR;
    logic                         isRem;
    logic                         byZero;
    logic                         overflow;
    logic                         signedOp;
    word_t                        absA;
    word_t                        absB;
    logic [WordWidth:0]           remShift;
    logic [WordWidth:0]           trial;
    logic                         fits;
    word_t                        quoFix;
    word_t                        remFix;

    assign signedOp = (divIn.divOp == DivQuot) || (divIn.divOp == DivRem);
    assign absA = (signedOp && divIn.dividend[WordWidth-1]) ? -divIn.dividend : divIn.dividend;
    assign absB = (signedOp && divIn.divisor[WordWidth-1]) ? -divIn.divisor : divIn.divisor;

    // Restoring step
    assign remShift = {rem, quo[WordWidth-1]};
    assign trial = remShift - {1'b0, divisorMag};
    assign fits = (remShift >= {1'b0, divisorMag});

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= DivIdle;
            count <= '0;
        end else begin
            case (state)
                DivIdle: begin
                    if (divIn.start) begin
                        state <= DivRun;
                        count <= '0;
                    end
                end
                DivRun: begin
                    count <= count + 1'b1;
                    if (count == DivCycles - 1) begin
                        state <= DivDone;
                    end
                end
                default: begin
                    state <= DivIdle;   // Done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == DivIdle) && divIn.start) begin
            quo <= absA;
            rem <= '0;
            divisorMag <= absB;
            dividendSave <= divIn.dividend;
            negQ <= signedOp && (divIn.dividend[WordWidth-1] ^ divIn.divisor[WordWidth-1]);
            negR <= signedOp && divIn.dividend[WordWidth-1];
            isRem <= (divIn.divOp == DivRem) || (divIn.divOp == DivRemU);
            byZero <= (divIn.divisor == '0);
            overflow <= signedOp && (divIn.dividend == {1'b1, {(WordWidth-1){1'b0}}})
                        && (divIn.divisor == '1);
        end else if (state == DivRun) begin
            rem <= fits ? trial[WordWidth-1:0] : remShift[WordWidth-1:0];
            quo <= {quo[WordWidth-2:0], fits};
        end
    end

    assign quoFix = negQ ? -quo : quo;
    assign remFix = negR ? -rem : rem;

    // RISC-V rules for divide by zero and overflow
    assign divOut.result = byZero   ? (isRem ? dividendSave : '1) :
                           overflow ? (isRem ? '0 : dividendSave) :
                                      (isRem ? remFix : quoFix);

    assign divOut.busy = (state != DivIdle);
    assign divOut.done = (state == DivDone);

    noStartWhileBusy: assert property (
        @(posedge CLK) disable iff (rst)
        !(divIn.start && divOut.busy)
    ) else $error("divider start while busy");

endmodule

/* vectorFunctionalUnit.f */
vfuPkg.sv
vectorAlu.sv
vectorMultiplier.sv
vectorDivider.sv
vectorFunctionalUnit.sv
vfuChecker.sv
tbVectorFunctionalUnit.sv

/* vectorFunctionalUnit.sv */
module vectorFunctionalUnit (
    input  logic             CLK,
    input  logic             rst,
    input  vfuPkg::vfuReq_t  req,
    output vfuPkg::vfuResp_t resp,
    output logic             stall
);
    import vfuPkg::*;

    typedef struct packed {
        logic  valid;
        logic  isMul;       // Result comes from multiplier at the output
        word_t result;
    } stage_t;

    stage_t [PipeLatency-1:0] pipe;
    stage_t                   pipeOut;
    vfuResp_t                 divResp;
    mulIn_t                   mulIn;
    mulOut_t                  mulOut;
    divIn_t                   divIn;
    divOut_t                  divOut;
    word_t                    aluResult;
    logic                     accept;
    logic                     isMul;
    logic                     isDiv;
    logic                     passOpA;
    logic                     pipeBusy;

    assign isMul = (req.op.unit == UnitMul) && !req.maskBit;
    assign isDiv = (req.op.unit == UnitDiv) && !req.maskBit;
    assign passOpA = req.maskBit && ((req.op.unit == UnitMul) || (req.op.unit == UnitDiv));

    always_comb begin
        pipeBusy = 1'b0;
        for (int i = 0; i < PipeLatency; i++) begin
            pipeBusy = pipeBusy | pipe[i].valid;
        end
    end

    // Divides wait for an empty pipeline and everything waits on the divider
    assign stall = divOut.busy || (req.valid && isDiv && pipeBusy);
    assign accept = req.valid && !stall;

    vectorAlu aluInst (
        .opA     (req.opA),
        .opB     (req.opB),
        .maskBit (req.maskBit),
        .sew     (req.sew),
        .op      (req.op),
        .result  (aluResult)
    );

    assign mulIn = '{en: accept && isMul, opA: req.opA, opB: req.opB, mulOp: req.op.mulOp};
    assign divIn = '{start: accept && isDiv, dividend: req.opA, divisor: req.opB,
                     divOp: req.op.divOp};

    vectorMultiplier mulInst (
        .CLK,
        .rst,
        .mulIn,
        .mulOut
    );

    vectorDivider divInst (
        .CLK,
        .rst,
        .divIn,
        .divOut
    );

    always_ff @(posedge CLK) begin
        pipe[0].result <= passOpA ? req.opA : aluResult;
        for (int i = 1; i < PipeLatency; i++) begin
            pipe[i].result <= pipe[i-1].result;
        end
        divResp.result <= divOut.result;
        if (rst) begin
            for (int i = 0; i < PipeLatency; i++) begin
                pipe[i].valid <= 1'b0;
                pipe[i].isMul <= 1'b0;
            end
            divResp.valid <= 1'b0;
        end else begin
            pipe[0].valid <= accept && !isDiv;
            pipe[0].isMul <= accept && isMul;
            for (int i = 1; i < PipeLatency; i++) begin
                pipe[i].valid <= pipe[i-1].valid;
                pipe[i].isMul <= pipe[i-1].isMul;
            end
            divResp.valid <= divOut.done;
        end
    end

    assign pipeOut = pipe[PipeLatency-1];

    always_comb begin
        resp.valid = pipeOut.valid || divResp.valid;
        if (divResp.valid) begin
            resp.result = divResp.result;
        end else if (pipeOut.isMul) begin
            resp.result = mulOut.product;
        end else begin
            resp.result = pipeOut.result;
        end
    end

    noDivCollision: assert property (
        @(posedge CLK) disable iff (rst)
        !(pipeBusy && divOut.done)
    ) else $error("pipeline result collides with divider done");

    mulAligned: assert property (
        @(posedge CLK) disable iff (rst)
        (pipeOut.valid && pipeOut.isMul) |-> mulOut.valid
    ) else $error("multiplier product not aligned with output stage");

endmodule

/* vectorMultiplier.sv */
module vectorMultiplier (
    input  logic            CLK,
    input  logic            rst,
    input  vfuPkg::mulIn_t  mulIn,
    output vfuPkg::mulOut_t mulOut
);
    import vfuPkg::*;

    logic                          signExtA;
    logic                          signExtB;
    logic signed [WordWidth:0]     extA;
    logic signed [WordWidth:0]     extB;
    logic signed [2*WordWidth+1:0] partial;
    mulOp_e                        stageOp;
    logic                          stageValid;
    logic                          outValid;
    word_t                         outProduct;

    // Operand signedness per multiply form
    always_comb begin
        signExtA = (mulIn.mulOp != MulHighU);
        signExtB = (mulIn.mulOp == MulLow) || (mulIn.mulOp == MulHigh);
    end

    assign extA = {signExtA & mulIn.opA[WordWidth-1], mulIn.opA};
    assign extB = {signExtB & mulIn.opB[WordWidth-1], mulIn.opB};

    // Stage one holds the full 33x33 product
    always_ff @(posedge CLK) begin
        if (mulIn.en) begin
            partial <= extA * extB;
            stageOp <= mulIn.mulOp;
        end
    end

    // Stage two picks the half
    always_ff @(posedge CLK) begin
        if (stageValid) begin
            if (stageOp == MulLow) begin
                outProduct <= partial[WordWidth-1:0];
            end else begin
                outProduct <= partial[2*WordWidth-1:WordWidth];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            stageValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            stageValid <= mulIn.en;
            outValid <= stageValid;
        end
    end

    assign mulOut.valid = outValid;
    assign mulOut.product = outProduct;

    validFollowsEn: assert property (
        @(posedge CLK) disable iff (rst)
        mulOut.valid |-> $past(mulIn.en, 2)
    ) else $error("multiplier valid without en two cycles earlier");

endmodule

/* vfuChecker.sv */
module vfuChecker (
    input  logic             CLK,
    input  logic             rst,
    input  vfuPkg::vfuReq_t  req,
    input  vfuPkg::vfuResp_t resp,
    input  logic             stall,
    output int               valueErrors,
    output int               otherErrors,
    output int               pendingCount
);
    import vfuPkg::*;

    typedef struct packed {
        word_t       value;
        logic [31:0] due;       // Negedge count when resp is expected
        logic        isDiv;
    } expect_t;

    expect_t     expQ[$];
    expect_t     head;
    expect_t     entry;
    logic [31:0] cycle;
    logic        seenAccept;
    logic        divInFlight;

    function automatic logic isDivReq(vfuReq_t r);
        return (r.op.unit == UnitDiv) && !r.maskBit;
    endfunction

    function automatic word_t aluModel(vfuReq_t r);
        word_t       a;
        word_t       b;
        logic [4:0]  sh;
        logic        lt;
        logic [32:0] sumC;
        logic [32:0] sumN;
        logic [32:0] difB;
        logic [32:0] difN;
        a = r.opA;
        b = r.opB;
        if (r.sew == Sew8) begin
            sh = {2'b00, b[2:0]};
        end else if (r.sew == Sew16) begin
            sh = {1'b0, b[3:0]};
        end else begin
            sh = b[4:0];
        end
        lt = r.op.isUnsigned ? (a < b) : ($signed(a) < $signed(b));
        sumN = {1'b0, a} + {1'b0, b};
        sumC = sumN + {32'b0, r.maskBit};
        difN = {1'b0, a} - {1'b0, b};
        difB = difN - {32'b0, r.maskBit};
        case (r.op.aluOp)
            AluAdd:     return a + b;
            AluSub:     return a - b;
            AluRsb:     return b - a;
            AluAdc:     return sumC[31:0];
            AluSbc:     return difB[31:0];
            AluMadc:    return word_t'(sumC[32]);
            AluMadcNoC: return word_t'(sumN[32]);
            AluMsbc:    return word_t'(difB[32]);
            AluMsbcNoB: return word_t'(difN[32]);
            AluAnd:     return a & b;
            AluOr:      return a | b;
            AluXor:     return a ^ b;
            AluSll:     return a << sh;
            AluSrl:     return a >> sh;
            AluSra:     return word_t'($signed(a) >>> sh);
            AluSeq:     return word_t'(a == b);
            AluSne:     return word_t'(a != b);
            AluSlt:     return word_t'(lt);
            AluSle:     return word_t'(lt || (a == b));
            AluSgt:     return word_t'(!lt && (a != b));
            AluMin:     return lt ? a : b;
            AluMax:     return lt ? b : a;
            AluMerge:   return r.maskBit ? b : a;
            default:    return b;           // Move
        endcase
    endfunction

    function automatic word_t mulModel(vfuReq_t r);
        logic [63:0] a64;
        logic [63:0] b64;
        logic [63:0] p;
        a64 = {{32{r.opA[31] && (r.op.mulOp != MulHighU)}}, r.opA};
        b64 = {{32{r.opB[31] && (r.op.mulOp == MulHigh)}}, r.opB};
        p = a64 * b64;
        return (r.op.mulOp == MulLow) ? p[31:0] : p[63:32];
    endfunction

    function automatic word_t divModel(vfuReq_t r);
        logic isSigned;
        logic wantRem;
        isSigned = (r.op.divOp == DivQuot) || (r.op.divOp == DivRem);
        wantRem = (r.op.divOp == DivRem) || (r.op.divOp == DivRemU);
        if (r.opB == '0) begin
            return wantRem ? r.opA : 32'hffff_ffff;
        end
        if (isSigned && (r.opA == 32'h8000_0000) && (r.opB == 32'hffff_ffff)) begin
            return wantRem ? 32'h0 : r.opA;
        end
        if (!isSigned) begin
            return wantRem ? (r.opA % r.opB) : (r.opA / r.opB);
        end
        if (wantRem) begin
            return word_t'($signed(r.opA) % $signed(r.opB));
        end
        return word_t'($signed(r.opA) / $signed(r.opB));
    endfunction

    function automatic word_t modelResult(vfuReq_t r);
        if ((r.op.unit == UnitMul || r.op.unit == UnitDiv) && r.maskBit) begin
            return r.opA;   // Masked pass-through
        end
        if (r.op.unit == UnitMul) begin
            return mulModel(r);
        end
        if (r.op.unit == UnitDiv) begin
            return divModel(r);
        end
        return aluModel(r);
    endfunction

    initial begin
        valueErrors = 0;
        otherErrors = 0;
        pendingCount = 0;
        cycle = '0;
        seenAccept = 1'b0;
        divInFlight = 1'b0;
    end

    always @(negedge CLK) begin
        cycle = cycle + 1;
        if (!rst) begin
            if (resp.valid) begin
                if (expQ.size() == 0) begin
                    $display("Response at cycle %0d with no request outstanding", cycle);
                    otherErrors++;
                end else begin
                    head = expQ.pop_front();
                    if (head.isDiv) begin
                        divInFlight = 1'b0;
                    end
                    if (resp.result !== head.value) begin
                        $display("ERROR resp.result expected %08h actual %08h",
                                 head.value, resp.result);
                        valueErrors++;
                    end
                    if (cycle != head.due) begin
                        $display("Response at cycle %0d was due at cycle %0d", cycle, head.due);
                        otherErrors++;
                    end
                end
            end
            if (divInFlight && !stall) begin
                $display("Stall dropped at cycle %0d while a divide was running", cycle);
                otherErrors++;
            end
            if (stall && (!seenAccept || (!divInFlight && !isDivReq(req)))) begin
                $display("Stall high at cycle %0d with no divide waiting or running", cycle);
                otherErrors++;
            end
            if (req.valid && !stall) begin
                entry.value = modelResult(req);
                entry.isDiv = isDivReq(req);
                entry.due = cycle + (entry.isDiv ? DivCycles + 2 : PipeLatency);
                expQ.push_back(entry);
                seenAccept = 1'b1;
                divInFlight = divInFlight || entry.isDiv;
            end
        end
        pendingCount = expQ.size();
    end

endmodule

/* vfuPkg.sv */
package vfuPkg;

    localparam int WordWidth = 32;
    localparam int PipeLatency = 2;     // Accept to resp for ALU and multiply
    localparam int DivCycles = 32;      // One quotient bit per iteration

    typedef logic [WordWidth-1:0] word_t;

    typedef enum logic [1:0] {
        Sew8  = 2'd0,
        Sew16 = 2'd1,
        Sew32 = 2'd2
    } vsew_e;

    typedef enum logic [1:0] {
        UnitAlu = 2'd0,
        UnitMul = 2'd1,
        UnitDiv = 2'd2
    } vfuUnit_e;

    typedef enum logic [4:0] {
        AluAdd, AluSub, AluRsb, AluAdc, AluSbc,
        AluMadc, AluMadcNoC, AluMsbc, AluMsbcNoB,
        AluAnd, AluOr, AluXor,
        AluSll, AluSrl, AluSra,
        AluSeq, AluSne, AluSlt, AluSle, AluSgt,
        AluMin, AluMax, AluMerge, AluMove
    } aluOp_e;

    typedef enum logic [1:0] {
        MulLow    = 2'd0,
        MulHigh   = 2'd1,   // Signed x signed
        MulHighU  = 2'd2,   // Unsigned x unsigned
        MulHighSU = 2'd3    // Signed opA x unsigned opB
    } mulOp_e;

    typedef enum logic [1:0] {
        DivQuot  = 2'd0,
        DivRem   = 2'd1,
        DivQuotU = 2'd2,
        DivRemU  = 2'd3
    } divOp_e;

    typedef struct packed {
        vfuUnit_e unit;
        aluOp_e   aluOp;
        mulOp_e   mulOp;
        divOp_e   divOp;
        logic     isUnsigned;   // Compares, min and max
    } vfuOp_t;

    typedef struct packed {
        logic   valid;
        word_t  opA;
        word_t  opB;
        logic   maskBit;
        vsew_e  sew;
        vfuOp_t op;
    } vfuReq_t;

    typedef struct packed {
        logic  valid;
        word_t result;
    } vfuResp_t;

    typedef struct packed {
        logic   en;
        word_t  opA;
        word_t  opB;
        mulOp_e mulOp;
    } mulIn_t;

    typedef struct packed {
        logic  valid;
        word_t product;
    } mulOut_t;

    typedef struct packed {
        logic   start;
        word_t  dividend;
        word_t  divisor;
        divOp_e divOp;
    } divIn_t;

    typedef struct packed {
        logic  busy;
        logic  done;
        word_t result;
    } divOut_t;

endpackage
